// File: Makefile
# Verilator lint and simulation of the trace monitor

TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
LFLAGS   = --lint-only --timing --assert
TOP      = tb_trace_mon
FLIST    = build.f
OBJ      = obj_dir
LOG      = sim.log
FAIL_MSG = *** TEST FAILED ***
PASS_MSG = *** TEST PASSED ***

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LFLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(OBJ) -o $(TOP)
	./$(OBJ)/$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -qF '$(FAIL_MSG)' $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -qF '$(PASS_MSG)' $(LOG); then echo "Simulation ended without a result"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf $(OBJ) $(LOG)

// File: build.f
trace_pkg.sv
trace_capture.sv
nop_decoder.sv
event_merge.sv
trace_mon_top.sv
trace_mon_asserts.sv
tb_trace_mon.sv

// File: event_merge.sv
// Event merge with per-core event queues, round-robin output and exit and overflow flags
`timescale 1ns/10ps

module event_merge #(
   parameter int NUM_CORES  = 2,
   // Power of two and at least 2
   parameter int FIFO_DEPTH = 4
) (
   input  logic                                    clk,
   input  logic                                    rst_n_i,
   input  trace_pkg::sim_event_t [NUM_CORES-1:0]   evt_i,
   input  logic                  [NUM_CORES-1:0]   evt_valid_i,
   output trace_pkg::sim_event_t                   out_evt_o,
   output logic                                    out_valid_o,
   output logic                  [NUM_CORES-1:0]   term_o,
   output logic                                    term_all_o,
   output logic                                    overflow_o
);

   import trace_pkg::*;

   localparam int PTR_W  = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
   localparam int CNT_W  = PTR_W + 1;
   localparam int CORE_W = (NUM_CORES > 1) ? $clog2(NUM_CORES) : 1;

   // Queue storage with one ring per core
   sim_event_t mem_q [NUM_CORES][FIFO_DEPTH];

   logic [PTR_W-1:0] wr_ptr_q [NUM_CORES];
   logic [PTR_W-1:0] rd_ptr_q [NUM_CORES];
   logic [CNT_W-1:0] cnt_q    [NUM_CORES];

   // Core served most recently
   logic [CORE_W-1:0] rr_q;

   logic [NUM_CORES-1:0] nonempty;
   logic [NUM_CORES-1:0] full;
   logic [NUM_CORES-1:0] push_ok;
   logic [NUM_CORES-1:0] pop_c;
   logic [CORE_W-1:0]    sel;

   always_comb begin
      for (int c = 0; c < NUM_CORES; c++) begin
         nonempty[c] = (cnt_q[c] != '0);
         full[c]     = (cnt_q[c] == CNT_W'(FIFO_DEPTH));
         // Full queue on arrival drops the newest event
         push_ok[c]  = evt_valid_i[c] && !full[c];
      end
   end

   // Round-robin pick starting after the last core served
   always_comb begin
      int  idx;
      logic found;
      sel   = rr_q;
      found = 1'b0;
      for (int k = 1; k <= NUM_CORES; k++) begin
         idx = int'(rr_q) + k;
         if (idx >= NUM_CORES) begin
            idx = idx - NUM_CORES;
         end
         if (!found && nonempty[idx]) begin
            found = 1'b1;
            sel   = CORE_W'(idx);
         end
      end
   end

   // Head of the chosen queue goes out at one event per cycle
   assign out_valid_o = |nonempty;
   assign out_evt_o   = mem_q[sel][rd_ptr_q[sel]];

   always_comb begin
      for (int c = 0; c < NUM_CORES; c++) begin
         pop_c[c] = out_valid_o && (sel == CORE_W'(c));
      end
   end

   // Queue storage write
   always_ff @(posedge clk) begin
      for (int c = 0; c < NUM_CORES; c++) begin
         if (push_ok[c]) begin
            mem_q[c][wr_ptr_q[c]] <= evt_i[c];
         end
      end
   end

   // Pointers and occupancy
   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         for (int c = 0; c < NUM_CORES; c++) begin
            wr_ptr_q[c] <= '0;
            rd_ptr_q[c] <= '0;
            cnt_q[c]    <= '0;
         end
         rr_q <= '0;
      end else begin
         for (int c = 0; c < NUM_CORES; c++) begin
            if (push_ok[c]) begin
               wr_ptr_q[c] <= wr_ptr_q[c] + 1'b1;
            end
            if (pop_c[c]) begin
               rd_ptr_q[c] <= rd_ptr_q[c] + 1'b1;
            end
            case ({push_ok[c], pop_c[c]})
               2'b10:   cnt_q[c] <= cnt_q[c] + 1'b1;
               2'b01:   cnt_q[c] <= cnt_q[c] - 1'b1;
               default: cnt_q[c] <= cnt_q[c];
            endcase
         end
         if (out_valid_o) begin
            rr_q <= sel;
         end
      end
   end

   // Sticky exit and overflow flags
   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         term_o     <= '0;
         overflow_o <= 1'b0;
      end else begin
         // Exit flag rises the cycle after the event leaves
         if (out_valid_o && (out_evt_o.kind == EVT_EXIT)) begin
            term_o[sel] <= 1'b1;
         end
         if (|(evt_valid_i & full)) begin
            overflow_o <= 1'b1;
         end
      end
   end

   // All cores done
   assign term_all_o = &term_o;

endmodule

// File: nop_decoder.sv
// No-op decoder that tracks the per-core r3 shadow and turns marked no-ops into events
`timescale 1ns/10ps

module nop_decoder #(
   parameter int NUM_CORES = 2
) (
   input  logic                                       clk,
   input  logic                                       rst_n_i,
   input  trace_pkg::marked_trace_t [NUM_CORES-1:0]   marked_i,
   output trace_pkg::sim_event_t    [NUM_CORES-1:0]   evt_o,
   output logic                     [NUM_CORES-1:0]   evt_valid_o
);

   import trace_pkg::*;

   // Only exit, report and putc produce events
   function automatic logic code_known(nop_code_t code);
      return (code == NOP_EXIT) || (code == NOP_REPORT) || (code == NOP_PUTC);
   endfunction

   // Map a known code onto its event kind
   function automatic evt_kind_t code_to_kind(nop_code_t code);
      evt_kind_t kind;
      case (code)
         NOP_EXIT:   kind = EVT_EXIT;
         NOP_REPORT: kind = EVT_REPORT;
         default:    kind = EVT_PUTC;
      endcase
      return kind;
   endfunction

   // r3 shadow per core
   word_t [NUM_CORES-1:0] shadow_q;

   logic [NUM_CORES-1:0] wb_r3;
   logic [NUM_CORES-1:0] evt_hit;

   always_comb begin
      for (int c = 0; c < NUM_CORES; c++) begin
         // Writeback into r3 from a retired record
         wb_r3[c] = marked_i[c].trace.valid && marked_i[c].trace.wben &&
                    (marked_i[c].trace.wbreg == R3_INDEX);
         // Unknown codes are silently dropped here
         evt_hit[c] = marked_i[c].is_nop && code_known(marked_i[c].code);
      end
   end

   // Shadow registers and event strobes
   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         shadow_q    <= '0;
         evt_valid_o <= '0;
      end else begin
         for (int c = 0; c < NUM_CORES; c++) begin
            if (wb_r3[c]) begin
               shadow_q[c] <= marked_i[c].trace.wbdata;
            end
            evt_valid_o[c] <= evt_hit[c];
         end
      end
   end

   // Event payload
   always_ff @(posedge clk) begin
      for (int c = 0; c < NUM_CORES; c++) begin
         if (evt_hit[c]) begin
            evt_o[c].kind  <= code_to_kind(marked_i[c].code);
            evt_o[c].core  <= core_id_t'(c);
            // Shadow before this record's own writeback
            evt_o[c].value <= shadow_q[c];
         end
      end
   end

endmodule

// File: tb_trace_mon.sv
// Testbench for the trace monitor checking random trace records against an event model
`timescale 1ns/10ps

module tb_trace_mon;

   import trace_pkg::*;

   localparam int NUM_CORES      = 2;
   localparam int FIFO_DEPTH     = 4;
   localparam int NORMAL_CYCLES  = 400;
   localparam int EXIT_CYCLES    = NUM_CORES * (NUM_CORES + 6);
   localparam int BURST_CYCLES   = 40;
   localparam int STIM_CYCLES    = 10 + NORMAL_CYCLES + EXIT_CYCLES + BURST_CYCLES;
   localparam int TIMEOUT_CYCLES = 2 * STIM_CYCLES + 100;

   // Stimulus phases
   localparam int PH_IDLE   = 0;
   localparam int PH_NORMAL = 1;
   localparam int PH_EXIT   = 2;
   localparam int PH_BURST  = 3;

   logic                          clk;
   logic                          rst_n_i;
   exec_trace_t [NUM_CORES-1:0]   trace_i;
   sim_event_t                    out_evt_o;
   logic                          out_valid_o;
   logic        [NUM_CORES-1:0]   term_o;
   logic                          term_all_o;
   logic                          overflow_o;

   // Model state
   logic [31:0]          rng;
   word_t                shadow [NUM_CORES];
   int                   gap [NUM_CORES];
   sim_event_t           exp_q [NUM_CORES][$];
   // Events on their way through capture and decode
   logic [NUM_CORES-1:0] st_v [3];
   sim_event_t           st_e [3][NUM_CORES];
   // Event seen at the output and popped at the next rising edge
   logic                 pop_v;
   int                   pop_core;
   evt_kind_t            pop_kind;
   logic [NUM_CORES-1:0] term_exp;
   logic                 ovf_exp;
   int                   drops;
   int                   err_evt;
   int                   err_flag;
   int                   err_other;
   int                   cycles = 0;

   trace_mon_top #(
      .NUM_CORES  (NUM_CORES),
      .FIFO_DEPTH (FIFO_DEPTH)
   ) trace_mon_top_inst (
      .clk         (clk),
      .rst_n_i     (rst_n_i),
      .trace_i     (trace_i),
      .out_evt_o   (out_evt_o),
      .out_valid_o (out_valid_o),
      .term_o      (term_o),
      .term_all_o  (term_all_o),
      .overflow_o  (overflow_o)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // Run length guard
   always @(posedge clk) begin
      cycles++;
      if (cycles >= TIMEOUT_CYCLES) begin
         $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("*** TEST FAILED ***");
         $finish;
      end
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   task automatic compare_event(input sim_event_t got, input sim_event_t exp);
      if (got !== exp) begin
         $display(
            "error at %0t: event kind %0d core %0d value %h, expected kind %0d core %0d value %h",
            $time, got.kind, got.core, got.value, exp.kind, exp.core, exp.value);
         err_evt++;
      end
   endtask

   task automatic compare_flag(input logic got, input logic exp, input string name);
      if (got !== exp) begin
         $display("error at %0t: %s is %b, expected %b", $time, name, got, exp);
         err_flag++;
      end
   endtask

   // Queue pushes, drops and pops of the rising edge just passed
   task automatic update_model();
      logic pend;
      for (int c = 0; c < NUM_CORES; c++) begin
         pend = pop_v && (pop_core == c);
         if (st_v[2][c]) begin
            // Occupancy before the edge still holds the event being popped
            if (exp_q[c].size() + (pend ? 1 : 0) >= FIFO_DEPTH) begin
               ovf_exp = 1'b1;
               drops++;
            end else begin
               exp_q[c].push_back(st_e[2][c]);
            end
         end
      end
      if (pop_v && (pop_kind == EVT_EXIT)) begin
         term_exp[pop_core] = 1'b1;
      end
   endtask

   task automatic check_outputs();
      logic       any;
      int         core;
      sim_event_t exp;
      any = 1'b0;
      for (int c = 0; c < NUM_CORES; c++) begin
         if (exp_q[c].size() != 0) begin
            any = 1'b1;
         end
      end
      compare_flag(out_valid_o, any, "out_valid_o");
      pop_v = 1'b0;
      if (out_valid_o === 1'b1) begin
         core = int'(out_evt_o.core);
         if (core >= NUM_CORES) begin
            $display("Event at %0t names core %0d, which does not exist", $time, core);
            err_other++;
         end else if (exp_q[core].size() == 0) begin
            $display("Event at %0t from core %0d came with nothing pending", $time, core);
            err_other++;
         end else begin
            exp = exp_q[core].pop_front();
            compare_event(out_evt_o, exp);
            pop_v    = 1'b1;
            pop_core = core;
            pop_kind = exp.kind;
         end
      end
      for (int c = 0; c < NUM_CORES; c++) begin
         compare_flag(term_o[c], term_exp[c], $sformatf("term_o[%0d]", c));
      end
      compare_flag(term_all_o, &term_exp, "term_all_o");
      compare_flag(overflow_o, ovf_exp, "overflow_o");
   endtask

   // One record for one core with the expected event if it makes one
   task automatic gen_record(input int c, input int phase, input int exit_core,
                             output exec_trace_t rec, output logic ev_v, output sim_event_t ev);
      logic [31:0] r;
      int          choice;
      nop_code_t   code;
      rng    = xorshift32(rng);
      r      = rng;
      rec    = '0;
      ev     = '0;
      ev_v   = 1'b0;
      rec.pc = {r[31:2], 2'b00};
      if (gap[c] > 0) begin
         gap[c]--;
      end
      choice = int'(r[2:0]);
      if (phase == PH_IDLE) begin
         choice = 0;
      end
      // Core 0 floods its queue while the others keep the merge busy
      if ((phase == PH_BURST) && ((c == 0) || (gap[c] == 0))) begin
         choice = 6;
      end
      if ((choice == 6) && (gap[c] != 0) && !((phase == PH_BURST) && (c == 0))) begin
         choice = 0;
      end
      if ((phase == PH_EXIT) && (c == exit_core)) begin
         choice = 8;
      end
      case (choice)
         6, 8: begin
            if (choice == 8) begin
               code    = NOP_EXIT;
               ev.kind = EVT_EXIT;
            end else if (r[8]) begin
               code    = NOP_REPORT;
               ev.kind = EVT_REPORT;
            end else begin
               code    = NOP_PUTC;
               ev.kind = EVT_PUTC;
            end
            rec.valid = 1'b1;
            rec.insn  = {NOP_OPCODE, r[23:16], code};
            // Shadow as left by earlier records only
            ev.core   = core_id_t'(c);
            ev.value  = shadow[c];
            ev_v      = 1'b1;
            gap[c]    = NUM_CORES + 1;
            // Some no-ops also write r3, seen only by later no-ops
            if (r[9]) begin
               rec.wben   = 1'b1;
               rec.wbreg  = R3_INDEX;
               rec.wbdata = ~r;
               shadow[c]  = ~r;
            end
         end
         7: begin
            code = r[31:16];
            if ((code == NOP_EXIT) || (code == NOP_REPORT) || (code == NOP_PUTC)) begin
               code = code ^ 16'h0100;
            end
            rec.valid = 1'b1;
            rec.insn  = {NOP_OPCODE, r[23:16], code};
         end
         3, 4, 5: begin
            rng        = xorshift32(rng);
            rec.valid  = 1'b1;
            rec.insn   = {8'h33, r[23:0]};
            rec.wben   = 1'b1;
            rec.wbdata = rng;
            rec.wbreg  = R3_INDEX;
            if (choice == 5) begin
               rec.wbreg = (r[12:8] == R3_INDEX) ? 5'd4 : r[12:8];
            end
            if (rec.wbreg == R3_INDEX) begin
               shadow[c] = rng;
            end
         end
         default: begin
            // Invalid slot dressed as a no-op with an r3 write
            rec.insn   = {NOP_OPCODE, 8'h00, NOP_REPORT};
            rec.wben   = 1'b1;
            rec.wbreg  = R3_INDEX;
            rec.wbdata = r;
         end
      endcase
   endtask

   task automatic run_cycle(input int phase, input int exit_core);
      exec_trace_t rec;
      logic        ev_v;
      sim_event_t  ev;
      @(negedge clk);
      update_model();
      check_outputs();
      for (int c = 0; c < NUM_CORES; c++) begin
         st_v[2][c] = st_v[1][c];
         st_e[2][c] = st_e[1][c];
         st_v[1][c] = st_v[0][c];
         st_e[1][c] = st_e[0][c];
         gen_record(c, phase, exit_core, rec, ev_v, ev);
         trace_i[c] = rec;
         st_v[0][c] = ev_v;
         st_e[0][c] = ev;
      end
   endtask

   function automatic logic drained();
      for (int c = 0; c < NUM_CORES; c++) begin
         if ((exp_q[c].size() != 0) || st_v[0][c] || st_v[1][c] || st_v[2][c]) begin
            return 1'b0;
         end
      end
      return !pop_v;
   endfunction

   initial begin
      rng       = 32'hbd0e;
      rst_n_i   = 1'b0;
      trace_i   = '0;
      pop_v     = 1'b0;
      pop_core  = 0;
      pop_kind  = EVT_EXIT;
      term_exp  = '0;
      ovf_exp   = 1'b0;
      drops     = 0;
      err_evt   = 0;
      err_flag  = 0;
      err_other = 0;
      for (int c = 0; c < NUM_CORES; c++) begin
         shadow[c] = '0;
         gap[c]    = 0;
         for (int k = 0; k < 3; k++) begin
            st_v[k][c] = 1'b0;
            st_e[k][c] = '0;
         end
      end
      repeat (2) @(posedge clk);
      @(negedge clk);
      rst_n_i = 1'b1;
      // Quiet start with flags low and no events
      repeat (10) run_cycle(PH_IDLE, 0);
      repeat (NORMAL_CYCLES) run_cycle(PH_NORMAL, 0);
      // Exits one core at a time
      for (int k = 0; k < NUM_CORES; k++) begin
         run_cycle(PH_EXIT, k);
         repeat (NUM_CORES + 5) run_cycle(PH_NORMAL, 0);
      end
      repeat (BURST_CYCLES) run_cycle(PH_BURST, 0);
      while (!drained()) begin
         run_cycle(PH_IDLE, 0);
      end
      repeat (4) run_cycle(PH_IDLE, 0);
      if (drops == 0) begin
         $display("The burst never filled a queue, so overflow was not exercised");
         err_other++;
      end
      $display("Errors: event %0d, flag %0d, other %0d", err_evt, err_flag, err_other);
      if ((err_evt + err_flag + err_other) == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule

// File: trace_capture.sv
// Trace input stage that registers each core's record and flags simulation no-ops
`timescale 1ns/10ps

module trace_capture #(
   parameter int NUM_CORES = 2
) (
   input  logic                                       clk,
   input  logic                                       rst_n_i,
   input  trace_pkg::exec_trace_t   [NUM_CORES-1:0]   trace_i,
   output trace_pkg::marked_trace_t [NUM_CORES-1:0]   marked_o
);

   import trace_pkg::*;

   // Valid and no-op marks
   logic [NUM_CORES-1:0] valid_q;
   logic [NUM_CORES-1:0] nop_q;

   // Record payload and no-op code
   exec_trace_t [NUM_CORES-1:0] rec_q;
   nop_code_t   [NUM_CORES-1:0] code_q;

   // No-op detect on the incoming record
   logic [NUM_CORES-1:0] nop_hit;

   always_comb begin
      for (int c = 0; c < NUM_CORES; c++) begin
         // Top byte match only counts for a retired instruction
         nop_hit[c] = trace_i[c].valid && (trace_i[c].insn[31:24] == NOP_OPCODE);
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         valid_q <= '0;
         nop_q   <= '0;
      end else begin
         for (int c = 0; c < NUM_CORES; c++) begin
            valid_q[c] <= trace_i[c].valid;
            nop_q[c]   <= nop_hit[c];
         end
      end
   end

   always_ff @(posedge clk) begin
      for (int c = 0; c < NUM_CORES; c++) begin
         rec_q[c]  <= trace_i[c];
         // Code field sits in the low half of the instruction
         code_q[c] <= trace_i[c].insn[15:0];
      end
   end

   // Merge control and payload into the outgoing records
   always_comb begin
      for (int c = 0; c < NUM_CORES; c++) begin
         marked_o[c].trace       = rec_q[c];
         marked_o[c].trace.valid = valid_q[c];
         marked_o[c].is_nop      = nop_q[c];
         marked_o[c].code        = code_q[c];
      end
   end

endmodule

// File: trace_mon_asserts.sv
// Concurrent checks on the event merge output strobe and exit flags
`timescale 1ns/10ps

module trace_mon_asserts #(
   parameter int NUM_CORES = 2,
   parameter int CORE_W    = (NUM_CORES > 1) ? $clog2(NUM_CORES) : 1
) (
   input logic                    clk,
   input logic                    rst_n_i,
   input logic [NUM_CORES-1:0]    nonempty_i,
   input logic [CORE_W-1:0]       sel_i,
   input logic                    out_valid_i,
   input trace_pkg::sim_event_t   out_evt_i,
   input logic [NUM_CORES-1:0]    term_i,
   input logic                    term_all_i
);

   import trace_pkg::*;

   // Exit event leaving the merge in this cycle
   logic exit_out;

   assign exit_out = out_valid_i && (out_evt_i.kind == EVT_EXIT);

   // Strobe only pops a queue that holds an entry
   a_valid_needs_entry: assert property (
      @(posedge clk) disable iff (!rst_n_i) out_valid_i |-> nonempty_i[sel_i]
   ) else $error("out_valid_o high while the selected queue is empty");

   for (genvar c = 0; c < NUM_CORES; c++) begin : g_term
      // Exit flag only changes by rising after an exit event of that core
      a_term_sticky: assert property (
         @(posedge clk) disable iff (!rst_n_i)
         (term_i[c] != $past(term_i[c])) |->
            (term_i[c] && $past(exit_out) && ($past(out_evt_i.core) == core_id_t'(c)))
      ) else $error("term_o[%0d] changed without an exit event from that core", c);
   end

   // All-done rises with the last exit and every core done
   a_term_all: assert property (
      @(posedge clk) disable iff (!rst_n_i)
      $rose(term_all_i) |-> ((&term_i) && $past(exit_out))
   ) else $error("term_all_o rose without a final exit event");

endmodule

bind event_merge trace_mon_asserts #(
   .NUM_CORES (NUM_CORES),
   .CORE_W    (CORE_W)
) trace_mon_asserts_inst (
   .clk         (clk),
   .rst_n_i     (rst_n_i),
   .nonempty_i  (nonempty),
   .sel_i       (sel),
   .out_valid_i (out_valid_o),
   .out_evt_i   (out_evt_o),
   .term_i      (term_o),
   .term_all_i  (term_all_o)
);

// File: trace_mon_top.sv
// Trace monitor top level chaining capture, no-op decode and event merge
`timescale 1ns/10ps

module trace_mon_top #(
   parameter int NUM_CORES  = 2,
   parameter int FIFO_DEPTH = 4
) (
   input  logic                                       clk,
   input  logic                                       rst_n_i,
   input  trace_pkg::exec_trace_t   [NUM_CORES-1:0]   trace_i,
   output trace_pkg::sim_event_t                      out_evt_o,
   output logic                                       out_valid_o,
   output logic                     [NUM_CORES-1:0]   term_o,
   output logic                                       term_all_o,
   output logic                                       overflow_o
);

   import trace_pkg::*;

   // Registered records with no-op marks
   marked_trace_t [NUM_CORES-1:0] marked;

   // Per-core events into the queues
   sim_event_t [NUM_CORES-1:0] evt;
   logic       [NUM_CORES-1:0] evt_valid;

   // Record capture with one cycle of latency
   trace_capture #(
      .NUM_CORES (NUM_CORES)
   ) trace_capture_inst (
      .clk      (clk),
      .rst_n_i  (rst_n_i),
      .trace_i  (trace_i),
      .marked_o (marked)
   );

   // Shadow r3 and event build with one cycle of latency
   nop_decoder #(
      .NUM_CORES (NUM_CORES)
   ) nop_decoder_inst (
      .clk         (clk),
      .rst_n_i     (rst_n_i),
      .marked_i    (marked),
      .evt_o       (evt),
      .evt_valid_o (evt_valid)
   );

   // Queues and single output stream
   event_merge #(
      .NUM_CORES  (NUM_CORES),
      .FIFO_DEPTH (FIFO_DEPTH)
   ) event_merge_inst (
      .clk         (clk),
      .rst_n_i     (rst_n_i),
      .evt_i       (evt),
      .evt_valid_i (evt_valid),
      .out_evt_o   (out_evt_o),
      .out_valid_o (out_valid_o),
      .term_o      (term_o),
      .term_all_o  (term_all_o),
      .overflow_o  (overflow_o)
   );

endmodule

// File: trace_pkg.sv
// Trace monitor package with trace record, event and width types
package trace_pkg;

   // Scalar field widths
   typedef logic [31:0] word_t;
   typedef logic [4:0]  reg_idx_t;
   typedef logic [15:0] nop_code_t;
   // Wide enough for any supported core count
   typedef logic [7:0]  core_id_t;

   // One retired instruction as seen at writeback
   typedef struct packed {
      logic     valid;
      word_t    pc;
      word_t    insn;
      logic     wben;
      reg_idx_t wbreg;
      word_t    wbdata;
   } exec_trace_t;

   // Registered record with the no-op decode attached
   typedef struct packed {
      exec_trace_t trace;
      logic        is_nop;
      nop_code_t   code;
   } marked_trace_t;

   // Simulation event kinds on two bits
   typedef enum logic [1:0] {
      EVT_EXIT   = 2'd0,
      EVT_REPORT = 2'd1,
      EVT_PUTC   = 2'd2
   } evt_kind_t;

   // Value is the r3 shadow at the time of the no-op
   typedef struct packed {
      evt_kind_t kind;
      core_id_t  core;
      word_t     value;
   } sim_event_t;

   // Top byte of a simulation-control no-op
   localparam logic [7:0] NOP_OPCODE = 8'h15;
   localparam nop_code_t  NOP_EXIT   = 16'd1;
   localparam nop_code_t  NOP_REPORT = 16'd2;
   localparam nop_code_t  NOP_PUTC   = 16'd4;
   localparam reg_idx_t   R3_INDEX   = 5'd3;

endpackage
